// ==== enoc_pkg.sv ====
/*
 * packet format for the network endpoint
 * widths, field positions, command layout and opcodes
 */
`default_nettype none

package enoc_pkg;

   localparam int AW = 32;              // address width
   localparam int PW = 112;             // packet width
   localparam int CW = 16;              // command field width
   localparam int DW = 2 * AW;          // data field width

   typedef logic [PW-1:0] packet_t;

   // field positions in the 112 bit packet
   localparam int CMD_LSB  = 0;
   localparam int DST_LSB  = 16;
   localparam int SRC_LSB  = 48;
   localparam int DATA_LSB = 48;        // low data word shares bits with srcaddr

   // command layout, bit 7 reserved
   localparam int OPC_LSB  = 0;
   localparam int OPC_W    = 4;
   localparam int SIZE_LSB = 4;
   localparam int SIZE_W   = 3;
   localparam int USER_LSB = 8;
   localparam int USER_W   = 8;

   // opcodes
   localparam logic [OPC_W-1:0] OP_WRITE = 4'h0;
   localparam logic [OPC_W-1:0] OP_READ  = 4'h8;
   localparam logic [OPC_W-1:0] OP_ADD   = 4'h9;
   localparam logic [OPC_W-1:0] OP_AND   = 4'ha;
   localparam logic [OPC_W-1:0] OP_OR    = 4'hb;
   localparam logic [OPC_W-1:0] OP_XOR   = 4'hc;
   localparam logic [OPC_W-1:0] OP_CAS   = 4'hd;
   localparam logic [OPC_W-1:0] OP_RESP  = 4'hf;   // response packets only

endpackage

`default_nettype wire

// ==== mem_pkg.sv ====
/*
 * local word memory definitions and memory operation codes
 */
`default_nettype none

package mem_pkg;

   localparam int MEM_DEPTH = 256;     // words
   localparam int IDX_W     = 8;       // word index width
   localparam int IDX_LSB   = 2;       // index from dstaddr[9:2]
   localparam int WORD_W    = 32;

   typedef enum logic [2:0] {
      MOP_READ  = 3'd0,
      MOP_WRITE = 3'd1,
      MOP_ADD   = 3'd2,
      MOP_AND   = 3'd3,
      MOP_OR    = 3'd4,
      MOP_XOR   = 3'd5,
      MOP_CAS   = 3'd6,
      MOP_NONE  = 3'd7
   } mem_op_t;

endpackage

`default_nettype wire

// ==== enoc_decode.sv ====
/*
 * command field decoder, opcode to memory operation
 */
`timescale 1ns/1ps
`default_nettype none

module enoc_decode (
   input  logic                         clk,
   input  logic                         in_valid,
   input  logic [enoc_pkg::CW-1:0]      cmd_in,
   output mem_pkg::mem_op_t             mem_op,
   output logic [enoc_pkg::OPC_W-1:0]   cmd_opcode,
   output logic [enoc_pkg::SIZE_W-1:0]  cmd_size,
   output logic [enoc_pkg::USER_W-1:0]  cmd_user
);

   import enoc_pkg::*;
   import mem_pkg::*;

   assign cmd_opcode = cmd_in[OPC_LSB +: OPC_W];
   assign cmd_size   = cmd_in[SIZE_LSB +: SIZE_W];
   assign cmd_user   = cmd_in[USER_LSB +: USER_W];

   always_comb begin
      case (cmd_opcode)
         OP_WRITE: mem_op = MOP_WRITE;
         OP_READ:  mem_op = MOP_READ;
         OP_ADD:   mem_op = MOP_ADD;
         OP_AND:   mem_op = MOP_AND;
         OP_OR:    mem_op = MOP_OR;
         OP_XOR:   mem_op = MOP_XOR;
         OP_CAS:   mem_op = MOP_CAS;
         OP_RESP:  mem_op = MOP_NONE;   // a response is no request
         default:  mem_op = MOP_NONE;
      endcase
   end

   // source must present a clean command with every valid
   a_cmd_known: assert property (@(posedge clk) in_valid |-> !$isunknown(cmd_in));

endmodule

`default_nettype wire

// ==== enoc_unpack.sv ====
/*
 * request packet unpacker, fixed 32 bit address / 112 bit layout
 */
`timescale 1ns/1ps
`default_nettype none

module enoc_unpack (
   input  logic                         clk,
   input  logic                         in_valid,
   input  enoc_pkg::packet_t            packet_in,
   output mem_pkg::mem_op_t             mem_op,
   output logic [enoc_pkg::OPC_W-1:0]   cmd_opcode,
   output logic [enoc_pkg::SIZE_W-1:0]  cmd_size,
   output logic [enoc_pkg::USER_W-1:0]  cmd_user,
   output logic [enoc_pkg::AW-1:0]      dstaddr,
   output logic [enoc_pkg::AW-1:0]      srcaddr,
   output logic [enoc_pkg::DW-1:0]      data
);

   import enoc_pkg::*;

   logic [CW-1:0] cmd;

   //############################################################
   // field slicing
   //############################################################
   assign cmd     = packet_in[CMD_LSB +: CW];
   assign dstaddr = packet_in[DST_LSB +: AW];   // target word
   assign srcaddr = packet_in[SRC_LSB +: AW];   // return address
   assign data    = packet_in[DATA_LSB +: DW];  // low word is srcaddr too

   enoc_decode decode_i (
      .clk        (clk),
      .in_valid   (in_valid),
      .cmd_in     (cmd),
      .mem_op     (mem_op),
      .cmd_opcode (cmd_opcode),
      .cmd_size   (cmd_size),
      .cmd_user   (cmd_user)
   );

endmodule

`default_nettype wire

// ==== enoc_pack.sv ====
/*
 * response packet assembly
 */
`timescale 1ns/1ps
`default_nettype none

module enoc_pack (
   input  logic [enoc_pkg::SIZE_W-1:0]  resp_size,
   input  logic [enoc_pkg::USER_W-1:0]  resp_user,
   input  logic [enoc_pkg::AW-1:0]      resp_dstaddr,
   input  logic [enoc_pkg::AW-1:0]      resp_srcaddr,
   input  logic [enoc_pkg::DW-1:0]      resp_data,
   output enoc_pkg::packet_t            packet_out
);

   import enoc_pkg::*;

   always_comb begin
      packet_out = '0;   // reserved bit stays low
      packet_out[CMD_LSB + OPC_LSB +: OPC_W]   = OP_RESP;
      packet_out[CMD_LSB + SIZE_LSB +: SIZE_W] = resp_size;
      packet_out[CMD_LSB + USER_LSB +: USER_W] = resp_user;
      packet_out[DST_LSB +: AW]  = resp_dstaddr;
      packet_out[SRC_LSB +: AW]  = resp_srcaddr;
      // data field is placed last and overlays the source address,
      // so the low data word (old memory word) is what travels there
      packet_out[DATA_LSB +: DW] = resp_data;
   end

endmodule

`default_nettype wire

// ==== atomic_alu.sv ====
/*
 * write back value and write enable per memory operation
 */
`timescale 1ns/1ps
`default_nettype none

module atomic_alu (
   input  mem_pkg::mem_op_t               mem_op,
   input  logic [mem_pkg::WORD_W-1:0]     old_word,
   input  logic [2*mem_pkg::WORD_W-1:0]   operand,
   output logic [mem_pkg::WORD_W-1:0]     new_word,
   output logic                           wr_en
);

   import mem_pkg::*;

   logic [WORD_W-1:0] op_lo;   // write data, atomic operand, cas compare
   logic [WORD_W-1:0] op_hi;   // cas swap value

   assign op_lo = operand[WORD_W-1:0];
   assign op_hi = operand[2*WORD_W-1:WORD_W];

   always_comb begin
      new_word = old_word;
      wr_en    = 1'b1;
      case (mem_op)
         MOP_WRITE: new_word = op_lo;
         MOP_ADD:   new_word = old_word + op_lo;
         MOP_AND:   new_word = old_word & op_lo;
         MOP_OR:    new_word = old_word | op_lo;
         MOP_XOR:   new_word = old_word ^ op_lo;
         MOP_CAS: begin
            new_word = op_hi;
            wr_en    = (old_word == op_lo);   // swap on match only
         end
         default:   wr_en = 1'b0;   // read and none
      endcase
   end

endmodule

`default_nettype wire

// ==== mem_endpoint.sv ====
/*
 * two stage memory pipeline with read, modify, write
 * same index forwarding and output back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module mem_endpoint (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         in_valid,
   input  mem_pkg::mem_op_t             mem_op,
   input  logic [enoc_pkg::SIZE_W-1:0]  cmd_size,
   input  logic [enoc_pkg::USER_W-1:0]  cmd_user,
   input  logic [enoc_pkg::AW-1:0]      dstaddr,
   input  logic [enoc_pkg::AW-1:0]      srcaddr,
   input  logic [enoc_pkg::DW-1:0]      data,
   output logic                         in_ready,
   input  logic                         out_ready,
   output logic                         out_valid,
   output logic [enoc_pkg::SIZE_W-1:0]  resp_size,
   output logic [enoc_pkg::USER_W-1:0]  resp_user,
   output logic [enoc_pkg::AW-1:0]      resp_dstaddr,
   output logic [enoc_pkg::AW-1:0]      resp_srcaddr,
   output logic [enoc_pkg::DW-1:0]      resp_data
);

   import enoc_pkg::*;
   import mem_pkg::*;

   logic [WORD_W-1:0] mem [MEM_DEPTH];

   // stage 1
   logic              s1_valid;
   mem_op_t           s1_op;
   logic [SIZE_W-1:0] s1_size;
   logic [USER_W-1:0] s1_user;
   logic [AW-1:0]     s1_dst, s1_src;
   logic [DW-1:0]     s1_data;
   logic [WORD_W-1:0] s1_word;   // read word

   // stage 2
   logic              s2_valid;
   mem_op_t           s2_op;
   logic [SIZE_W-1:0] s2_size;
   logic [USER_W-1:0] s2_user;
   logic [AW-1:0]     s2_dst, s2_src;
   logic [DW-1:0]     s2_data;
   logic [WORD_W-1:0] s2_word;

   logic [IDX_W-1:0]  in_idx, s1_idx, s2_idx;
   logic [WORD_W-1:0] new_word;
   logic              alu_wr_en, s2_resp, s2_done, s1_adv, accept, wr_fire;

   assign in_idx = dstaddr[IDX_LSB +: IDX_W];   // upper bits wrap
   assign s1_idx = s1_dst[IDX_LSB +: IDX_W];
   assign s2_idx = s2_dst[IDX_LSB +: IDX_W];

   //############################################################
   // handshake and stall
   //############################################################
   assign s2_resp  = (s2_op != MOP_WRITE) && (s2_op != MOP_NONE);
   assign s2_done  = s2_valid && (!s2_resp || out_ready);
   assign s1_adv   = s1_valid && (!s2_valid || s2_done);
   assign in_ready = !s1_valid || s1_adv;
   assign accept   = in_valid && in_ready;
   assign wr_fire  = s2_done && alu_wr_en;   // written once on completion

   atomic_alu alu_i (
      .mem_op   (s2_op),
      .old_word (s2_word),
      .operand  (s2_data),
      .new_word (new_word),
      .wr_en    (alu_wr_en)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         if (accept) s1_valid <= 1'b1;
         else if (s1_adv) s1_valid <= 1'b0;
         if (s1_adv) s2_valid <= 1'b1;
         else if (s2_done) s2_valid <= 1'b0;
      end
   end

   //############################################################
   // memory and payload
   //############################################################
   always_ff @(posedge clk) begin
      if (wr_fire) mem[s2_idx] <= new_word;
      if (accept) begin
         // same cycle write to the read index wins
         s1_word <= (wr_fire && s2_idx == in_idx) ? new_word : mem[in_idx];
         s1_op   <= mem_op;
         s1_size <= cmd_size;
         s1_user <= cmd_user;
         s1_dst  <= dstaddr;
         s1_src  <= srcaddr;
         s1_data <= data;
      end
      if (s1_adv) begin
         // word read while stage 2 was stalled may be stale
         s2_word <= (wr_fire && s2_idx == s1_idx) ? new_word : s1_word;
         s2_op   <= s1_op;
         s2_size <= s1_size;
         s2_user <= s1_user;
         s2_dst  <= s1_dst;
         s2_src  <= s1_src;
         s2_data <= s1_data;
      end
   end

   assign out_valid    = s2_valid && s2_resp;
   assign resp_size    = s2_size;
   assign resp_user    = s2_user;
   assign resp_dstaddr = s2_src;   // back to requester
   assign resp_srcaddr = s2_dst;
   assign resp_data    = {{(DW-WORD_W){1'b0}}, s2_word};   // old word

   a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid &&
      $stable({resp_size, resp_user, resp_dstaddr, resp_srcaddr, resp_data}));

   // input stalls only behind a full stage 1 and a blocked response
   a_in_ready_stall: assert property (@(posedge clk) disable iff (!rst_n)
      !in_ready |-> s1_valid && out_valid && !out_ready);

endmodule

`default_nettype wire

// ==== enoc_endpoint_top.sv ====
/*
 * memory endpoint top, unpacker to memory pipeline to packer
 */
`timescale 1ns/1ps
`default_nettype none

module enoc_endpoint_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   output logic               in_ready,
   input  enoc_pkg::packet_t  in_packet,
   output logic               out_valid,
   input  logic               out_ready,
   output enoc_pkg::packet_t  out_packet
);

   import enoc_pkg::*;
   import mem_pkg::*;

   // request fields
   mem_op_t           mem_op;
   logic [SIZE_W-1:0] cmd_size;
   logic [USER_W-1:0] cmd_user;
   logic [AW-1:0]     dstaddr;
   logic [AW-1:0]     srcaddr;
   logic [DW-1:0]     data;

   // response fields
   logic [SIZE_W-1:0] resp_size;
   logic [USER_W-1:0] resp_user;
   logic [AW-1:0]     resp_dstaddr;
   logic [AW-1:0]     resp_srcaddr;
   logic [DW-1:0]     resp_data;

   enoc_unpack unpack_i (
      .clk        (clk),
      .in_valid   (in_valid),
      .packet_in  (in_packet),
      .mem_op     (mem_op),
      .cmd_opcode (),            // raw opcode not needed past decode
      .cmd_size   (cmd_size),
      .cmd_user   (cmd_user),
      .dstaddr    (dstaddr),
      .srcaddr    (srcaddr),
      .data       (data)
   );

   mem_endpoint mem_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .mem_op       (mem_op),
      .cmd_size     (cmd_size),
      .cmd_user     (cmd_user),
      .dstaddr      (dstaddr),
      .srcaddr      (srcaddr),
      .data         (data),
      .in_ready     (in_ready),
      .out_ready    (out_ready),
      .out_valid    (out_valid),
      .resp_size    (resp_size),
      .resp_user    (resp_user),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data)
   );

   enoc_pack pack_i (
      .resp_size    (resp_size),
      .resp_user    (resp_user),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .packet_out   (out_packet)
   );

endmodule

`default_nettype wire

// ==== tb_enoc_endpoint.sv ====
/*
 * testbench for the memory endpoint, pattern driven requests,
 * random output back-pressure and in-order response checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_enoc_endpoint;

   import enoc_pkg::*;

   localparam int N_PAT      = 23;                // entries in the pattern file
   localparam int MAX_CYCLES = 20 * N_PAT + 100;

   logic    clk = 1'b0;
   logic    rst_n;
   logic    in_valid, in_ready;
   logic    out_valid, out_ready;
   packet_t in_packet, out_packet;

   packet_t     pat_mem [0:3*N_PAT-1];   // request, flag, response per entry
   packet_t     exp_q [$];
   logic [31:0] lfsr = 32'h836b_1e50;
   int          cycles = 0;

   enoc_endpoint_top dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_packet  (in_packet),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_packet (out_packet)
   );

   always #5 clk = ~clk;

   //############################################################
   // helpers
   //############################################################
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // taps 32 22 2 1
      return {s[30:0], fb};
   endfunction

   task automatic abort_run();
      $display("test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_packet(input string name, input packet_t expected,
                               input packet_t actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %b actual %b", $time, name, expected, actual);
         abort_run();
      end
   endtask

   //############################################################
   // back-pressure, response monitor, timeout
   //############################################################
   always @(negedge clk) begin
      lfsr      = lfsr_next(lfsr);
      out_ready = lfsr[0];   // one bit per step
   end

   always @(posedge clk) begin
      if (rst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("response arrived at %0t with none expected", $time);
            abort_run();
         end else begin
            check_packet("out_packet", exp_q.pop_front(), out_packet);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, %0d responses still missing",
                  cycles, exp_q.size());
         abort_run();
      end
   end

   //############################################################
   // stimulus
   //############################################################
   initial begin
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_packet = '0;
      out_ready = 1'b0;
      $readmemh("enoc_patterns.txt", pat_mem);

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_bit("out_valid", 1'b0, out_valid);   // idle after reset
      check_bit("in_ready", 1'b1, in_ready);

      for (int i = 0; i < N_PAT; i++) begin
         in_valid  = 1'b1;
         in_packet = pat_mem[3*i];
         if (pat_mem[3*i+1][0]) begin
            exp_q.push_back(pat_mem[3*i+2]);
         end
         @(posedge clk);
         while (!in_ready) @(posedge clk);   // held until accepted
         @(negedge clk);
      end
      in_valid  = 1'b0;
      in_packet = '0;

      while (exp_q.size() != 0) @(negedge clk);
      repeat (5) @(negedge clk);   // room for a stray response
      check_bit("out_valid", 1'b0, out_valid);   // nothing left over

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== enoc_patterns.txt ====
// columns: request packet, response expected flag (0 or 1), expected response packet
// packets are 112 bit hex: data high word, source address / data low word, dest address, command
0000000011112222000001000120 0 0000000000000000000000000000
00000000a5a5f00f000001040220 0 0000000000000000000000000000
0000000000008000000001000328 1 000000001111222200008000032f
0000000000008004000001040428 1 00000000a5a5f00f00008004042f
0000000000000010000001000529 1 000000001111222200000010052f
0000000000008000000001000628 1 000000001111223200008000062f
000000000f0f0f0f00000104072a 1 00000000a5a5f00f0f0f0f0f072f
00000000f000000000000104082b 1 000000000505000ff0000000082f
00000000ffff000000000104092c 1 00000000f505000fffff0000092f
0000000000008004000001040a28 1 000000000afa000f000080040a2f
0000000012345678000001080b20 0 0000000000000000000000000000
cafebabe12345678000001080c2d 1 0000000012345678123456780c2f
deadbeef00000000000001080d2d 1 00000000cafebabe000000000d2f
0000000000008008000001080e28 1 00000000cafebabe000080080e2f
0000000000000001000101000f29 1 0000000011112232000000010f2f
0000000000000002000005001029 1 000000001111223300000002102f
0000000000008000000001001128 1 000000001111223500008000112f
00000000000000000000010c1220 0 0000000000000000000000000000
00000000000000050000010c1329 1 000000000000000000000005132f
00000000000000070000010c1429 1 000000000000000500000007142f
000000000000800c0000010c1528 1 000000000000000c0000800c152f
00000000deadbeef000001001621 0 0000000000000000000000000000
0000000000008000000001001728 1 000000001111223500008000172f

// ==== list.f ====
enoc_pkg.sv
mem_pkg.sv
enoc_decode.sv
enoc_unpack.sv
enoc_pack.sv
atomic_alu.sv
mem_endpoint.sv
enoc_endpoint_top.sv
tb_enoc_endpoint.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   --top-module tb_enoc_endpoint -f list.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "test passed" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
